// ==== bench/axi_sram_asserts.sv ====
//--------------------------------------------------------------------------
// Protocol assertions on the AXI ports of axi_sram_top.
// Payload stability is checked only out of reset. The reset check
// starts on the second reset edge, once the DUT state is defined.
//--------------------------------------------------------------------------
`timescale 1ns/10ps

module axi_sram_asserts (
    input logic                           ACLK,
    input logic                           ARESETn,
    input logic [axi_cfg_pkg::ID_W-1:0]   BID, RID,
    input logic                           WREADY, BVALID, BREADY,
    input logic                           RVALID, RREADY, RLAST,
    input logic [axi_cfg_pkg::DATA_W-1:0] RDATA
);

    logic in_reset_q = 1'b0;   // Reset seen on the previous edge.
    int   failures   = 0;      // Assertion failures so far.

    always @(posedge ACLK) begin
        in_reset_q <= !ARESETn;
    end

    b_hold: assert property (@(posedge ACLK) disable iff (!ARESETn)
        BVALID && !BREADY |=> BVALID && $stable(BID))
        else begin
            $error("B response changed while stalled");
            failures++;
        end
    r_hold: assert property (@(posedge ACLK) disable iff (!ARESETn)
        RVALID && !RREADY |=> RVALID && $stable({RID, RDATA, RLAST}))
        else begin
            $error("R beat changed while stalled");
            failures++;
        end
    reset_quiet: assert property (@(posedge ACLK)
        in_reset_q && !ARESETn |-> !BVALID && !RVALID)
        else begin
            $error("BVALID or RVALID high during reset");
            failures++;
        end
    w_b_excl: assert property (@(posedge ACLK) disable iff (!ARESETn)
        !(WREADY && BVALID))
        else begin
            $error("WREADY and BVALID high together");
            failures++;
        end

endmodule

bind axi_sram_top axi_sram_asserts i_asserts (
    .ACLK, .ARESETn, .BID, .RID,
    .WREADY, .BVALID, .BREADY, .RVALID, .RREADY, .RLAST, .RDATA
);

// ==== bench/axi_sram_tb.sv ====
//--------------------------------------------------------------------------
// Testbench for the AXI4 SRAM slave.
// The whole memory is filled first, so later strobed writes land on
// known words. One burst per direction is in flight at a time.
// BREADY and RREADY are throttled at random in the middle phase.
// Every wait gives up after TIMEOUT cycles.
//--------------------------------------------------------------------------
`timescale 1ns/10ps

module axi_sram_tb;

    import axi_cfg_pkg::*;

    localparam int MEM_WORDS = 1 << MEM_ADDR_BITS;
    localparam int TIMEOUT   = 2000;            // Cycles per wait.
    localparam logic [1:0] AXI_OKAY = 2'b00;    // AXI OKAY response code.

    logic              ACLK = 1'b0;
    logic              ARESETn;
    logic [ID_W-1:0]   AWID, ARID, BID, RID;
    logic [ADDR_W-1:0] AWADDR, ARADDR;
    logic [LEN_W-1:0]  AWLEN, ARLEN;
    logic              AWVALID, AWREADY, ARVALID, ARREADY;
    logic [DATA_W-1:0] WDATA, RDATA;
    logic [STRB_W-1:0] WSTRB;
    logic              WLAST, WVALID, WREADY;
    logic [1:0]        BRESP, RRESP;
    logic              BVALID, RLAST, RVALID;
    logic              BREADY = 1'b1;
    logic              RREADY = 1'b1;

    logic [DATA_W-1:0] model [MEM_WORDS];       // Reference memory.
    logic [DATA_W-1:0] exp_data [$];
    logic [ID_W-1:0]   exp_id [$];
    bit                exp_last [$];
    integer            seed;
    integer            ready_seed;
    logic [31:0]       ready_rnd;
    bit                throttle;
    int                errors;
    int                beat_errors;
    int                timeouts;

    axi_sram_top i_dut (.*);

    always #4 ACLK = ~ACLK;

    function automatic logic [DATA_W-1:0] merge_strb(input logic [DATA_W-1:0] old_word,
            input logic [DATA_W-1:0] new_word, input logic [STRB_W-1:0] strb);
        logic [DATA_W-1:0] mask;
        mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
        return (old_word & ~mask) | (new_word & mask);
    endfunction

    function automatic logic [MEM_ADDR_BITS-1:0] model_index(input logic [ADDR_W-1:0] addr,
            input int beat);
        logic [ADDR_W-1:0] word;
        word = ((addr >> WORD_SHIFT) + ADDR_W'(beat)) % ADDR_W'(MEM_WORDS); // Aliased.
        return word[MEM_ADDR_BITS-1:0];
    endfunction

    function automatic logic [DATA_W-1:0] expected_beat(input logic [ADDR_W-1:0] addr,
            input int beat);
        return model[model_index(addr, beat)];
    endfunction

    function automatic logic [DATA_W-1:0] fill_word(input logic [MEM_ADDR_BITS-1:0] idx);
        return {6'h2a, idx, ~idx, 6'h15};
    endfunction

    task automatic report_mismatch(input string what, input logic [31:0] exp,
            input logic [31:0] got);
        errors++;
        $display("[FAIL] %t: %s expected %h, got %h", $time, what, exp, got);
    endtask

    task automatic report_beat_mismatch(input string what, input logic [31:0] exp,
            input logic [31:0] got);
        beat_errors++;
        $display("[FAIL] %t: R beat %s expected %h, got %h", $time, what, exp, got);
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        assert (got === exp) else report_mismatch(what, 32'(exp), 32'(got));
    endtask

    task automatic finish_run();
        int asrt_fails;
        asrt_fails = i_dut.i_asserts.failures;
        $display("Mismatches: %0d, assertion failures: %0d, timeouts: %0d",
                 errors + beat_errors, asrt_fails, timeouts);
        if (errors == 0 && beat_errors == 0 && timeouts == 0 && asrt_fails == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    endtask

    task automatic timeout_abort(input string what);
        timeouts++;
        $display("Timeout at %t: %s did not happen within %0d cycles", $time, what, TIMEOUT);
        finish_run();
    endtask

    task automatic write_burst(input logic [ID_W-1:0] id, input logic [ADDR_W-1:0] addr,
            input int len, input bit rand_strb, input bit fill);
        int                       n;
        logic [31:0]              rnd_data;
        logic [31:0]              rnd_strb;
        logic [MEM_ADDR_BITS-1:0] idx;
        logic [DATA_W-1:0]        data;
        logic [STRB_W-1:0]        strb;
        @(negedge ACLK);
        AWID    = id;
        AWADDR  = addr;
        AWLEN   = LEN_W'(len);
        AWVALID = 1'b1;
        n = 0;
        do begin
            @(posedge ACLK);
            n++;
            if (n > TIMEOUT) timeout_abort("AW handshake");
        end while (!AWREADY);
        for (int b = 0; b <= len; b++) begin
            @(negedge ACLK);
            rnd_data = $random(seed);
            rnd_strb = $random(seed);
            idx      = model_index(addr, b);
            data     = fill ? fill_word(idx) : rnd_data;
            strb     = (rand_strb && !fill) ? rnd_strb[STRB_W-1:0] : '1;
            AWVALID  = 1'b0;
            WDATA    = data;
            WSTRB    = strb;
            WLAST    = (b == len);
            WVALID   = 1'b1;
            n = 0;
            do begin
                @(posedge ACLK);
                n++;
                if (n > TIMEOUT) timeout_abort("W handshake");
            end while (!WREADY);
            model[idx] = merge_strb(model[idx], data, strb);
        end
        @(negedge ACLK);
        WVALID = 1'b0;
        WLAST  = 1'b0;
        n = 0;
        do begin
            @(posedge ACLK);
            n++;
            if (n > TIMEOUT) timeout_abort("B handshake");
        end while (!(BVALID && BREADY));
        assert (BID === id) else report_mismatch("BID", 32'(id), 32'(BID));
        assert (BRESP === AXI_OKAY) else report_mismatch("BRESP", 32'(AXI_OKAY), 32'(BRESP));
    endtask

    task automatic read_burst(input logic [ID_W-1:0] id, input logic [ADDR_W-1:0] addr,
            input int len);
        int n;
        for (int b = 0; b <= len; b++) begin
            exp_data.push_back(expected_beat(addr, b));
            exp_id.push_back(id);
            exp_last.push_back(b == len);      // RLAST only on beat ARLEN.
        end
        @(negedge ACLK);
        ARID    = id;
        ARADDR  = addr;
        ARLEN   = LEN_W'(len);
        ARVALID = 1'b1;
        n = 0;
        do begin
            @(posedge ACLK);
            n++;
            if (n > TIMEOUT) timeout_abort("AR handshake");
        end while (!ARREADY);
        @(negedge ACLK);
        ARVALID = 1'b0;
        n = 0;
        while (exp_data.size() != 0) begin  // Drained by the R monitor.
            @(negedge ACLK);
            n++;
            if (n > TIMEOUT) timeout_abort("R burst completion");
        end
    endtask

    task automatic random_pair();
        logic [31:0] r_addr;
        logic [31:0] r_len;
        logic [31:0] r_id;
        r_addr = $random(seed);
        r_len  = $random(seed);
        r_id   = $random(seed);
        write_burst(r_id[3:0], {r_addr[31:2], 2'b00}, int'(r_len[3:0]), 1'b1, 1'b0);
        read_burst(r_id[7:4], {r_addr[31:2], 2'b00}, int'(r_len[3:0]));
    endtask

    // Random backpressure on B and R.
    always @(negedge ACLK) begin
        if (throttle) begin
            ready_rnd = $random(ready_seed);
            BREADY    = ready_rnd[0];
            RREADY    = ready_rnd[1];
        end else begin
            BREADY = 1'b1;
            RREADY = 1'b1;
        end
    end

    // R beat comparison against the queued expectations.
    always @(posedge ACLK) begin
        if (ARESETn && RVALID && RREADY) begin
            assert (exp_data.size() != 0) else begin
                beat_errors++;
                $display("Unexpected R beat at %t with no read outstanding", $time);
            end
            if (exp_data.size() != 0) begin
                assert (RDATA === exp_data[0])
                    else report_beat_mismatch("RDATA", exp_data[0], RDATA);
                assert (RID === exp_id[0])
                    else report_beat_mismatch("RID", 32'(exp_id[0]), 32'(RID));
                assert (RLAST === exp_last[0])
                    else report_beat_mismatch("RLAST", 32'(exp_last[0]), 32'(RLAST));
                assert (RRESP === AXI_OKAY)
                    else report_beat_mismatch("RRESP", 32'(AXI_OKAY), 32'(RRESP));
                void'(exp_data.pop_front());
                void'(exp_id.pop_front());
                void'(exp_last.pop_front());
            end
        end
    end

    initial begin
        $timeformat(-9, 2, " ns", 0);
        seed       = 32'h083b881d;
        ready_seed = 32'h083b881d;
        throttle   = 1'b0;
        ARESETn = 1'b0;
        AWID    = '0;
        AWADDR  = '0;
        AWLEN   = '0;
        AWVALID = 1'b0;
        WDATA   = '0;
        WSTRB   = '0;
        WLAST   = 1'b0;
        WVALID  = 1'b0;
        ARID    = '0;
        ARADDR  = '0;
        ARLEN   = '0;
        ARVALID = 1'b0;
        repeat (16) @(posedge ACLK);
        @(negedge ACLK);
        ARESETn = 1'b1;
        @(posedge ACLK);
        check_bit("AWREADY after reset", AWREADY, 1'b1);
        check_bit("ARREADY after reset", ARREADY, 1'b1);
        check_bit("WREADY after reset", WREADY, 1'b0);
        check_bit("BVALID after reset", BVALID, 1'b0);
        check_bit("RVALID after reset", RVALID, 1'b0);
        for (int k = 0; k < MEM_WORDS / 256; k++) begin
            write_burst('0, ADDR_W'(k * 256 * (1 << WORD_SHIFT)), 255, 1'b0, 1'b1);
        end
        write_burst(4'h3, 32'h0000_0040, 0, 1'b0, 1'b0);   // Single beat.
        read_burst(4'h3, 32'h0000_0040, 0);
        repeat (30) random_pair();
        throttle = 1'b1;
        repeat (30) random_pair();
        throttle = 1'b0;
        write_burst(4'hA, 32'h0000_0FF8, 7, 1'b0, 1'b0);   // Runs past the top word.
        read_burst(4'hB, 32'h0000_1FF8, 7);
        read_burst(4'hC, 32'hFFFF_FFF8, 3);
        repeat (16) @(posedge ACLK);                        // Catch stray R beats.
        finish_run();
    end

endmodule

// ==== logic/axi_cfg_pkg.sv ====
//--------------------------------------------------------------------------
// Sizes of the AXI4 SRAM subsystem.
// Only full-word transfers are supported, so STRB_W is DATA_W / 8 and
// WORD_SHIFT must match it. The memory holds 2**MEM_ADDR_BITS words;
// higher address bits alias onto it.
//--------------------------------------------------------------------------
package axi_cfg_pkg;

    localparam int ADDR_W        = 32;         // AXI byte address.
    localparam int DATA_W        = 32;         // One word per beat.
    localparam int STRB_W        = DATA_W / 8;
    localparam int ID_W          = 4;
    localparam int LEN_W         = 8;          // Up to 256 beats.
    localparam int MEM_ADDR_BITS = 10;         // 1024 words.
    localparam int WORD_SHIFT    = 2;          // Byte bits below the word index.

endpackage

// ==== logic/axi_sram_top.sv ====
//--------------------------------------------------------------------------
// AXI4 slave SRAM, INCR bursts of full words only.
// No AxSIZE/AxBURST ports; every beat moves one word and responses
// are always OKAY. AW, AR and R pass through two-entry buffers.
//--------------------------------------------------------------------------
`timescale 1ns/10ps

module axi_sram_top (
    input  logic                            ACLK,
    input  logic                            ARESETn,
    input  logic [axi_cfg_pkg::ID_W-1:0]    AWID,
    input  logic [axi_cfg_pkg::ADDR_W-1:0]  AWADDR,
    input  logic [axi_cfg_pkg::LEN_W-1:0]   AWLEN,
    input  logic                            AWVALID,
    output logic                            AWREADY,
    input  logic [axi_cfg_pkg::DATA_W-1:0]  WDATA,
    input  logic [axi_cfg_pkg::STRB_W-1:0]  WSTRB,
    input  logic                            WLAST,
    input  logic                            WVALID,
    output logic                            WREADY,
    output logic [axi_cfg_pkg::ID_W-1:0]    BID,
    output logic [1:0]                      BRESP,
    output logic                            BVALID,
    input  logic                            BREADY,
    input  logic [axi_cfg_pkg::ID_W-1:0]    ARID,
    input  logic [axi_cfg_pkg::ADDR_W-1:0]  ARADDR,
    input  logic [axi_cfg_pkg::LEN_W-1:0]   ARLEN,
    input  logic                            ARVALID,
    output logic                            ARREADY,
    output logic [axi_cfg_pkg::ID_W-1:0]    RID,
    output logic [axi_cfg_pkg::DATA_W-1:0]  RDATA,
    output logic [1:0]                      RRESP,
    output logic                            RLAST,
    output logic                            RVALID,
    input  logic                            RREADY
);

    import axi_types_pkg::*;

    addr_req_t  aw_in;
    addr_req_t  aw_req;
    addr_req_t  ar_in;
    addr_req_t  ar_req;
    logic       aw_valid;
    logic       aw_ready;
    logic       ar_valid;
    logic       ar_ready;
    logic       r_valid;
    rbeat_t     r_beat;
    rbeat_t     r_out;
    logic [1:0] r_count;

    mem_port_if mem ();
    burst_if    wgen ();
    burst_if    rgen ();

    assign aw_in = '{id: AWID, addr: AWADDR, len: AWLEN};
    assign ar_in = '{id: ARID, addr: ARADDR, len: ARLEN};

    channel_slice #(.payload_t(addr_req_t)) i_aw_slice (
        .ACLK, .ARESETn,
        .in_valid(AWVALID), .in_ready(AWREADY), .in_data(aw_in),
        .out_valid(aw_valid), .out_ready(aw_ready), .out_data(aw_req),
        .count()
    );

    channel_slice #(.payload_t(addr_req_t)) i_ar_slice (
        .ACLK, .ARESETn,
        .in_valid(ARVALID), .in_ready(ARREADY), .in_data(ar_in),
        .out_valid(ar_valid), .out_ready(ar_ready), .out_data(ar_req),
        .count()
    );

    // Room is guaranteed by the controller's read credit.
    channel_slice #(.payload_t(rbeat_t)) i_r_slice (
        .ACLK, .ARESETn,
        .in_valid(r_valid), .in_ready(), .in_data(r_beat),
        .out_valid(RVALID), .out_ready(RREADY), .out_data(r_out),
        .count(r_count)
    );

    burst_addr_gen i_wgen (.ACLK, .ARESETn, .bus(wgen));
    burst_addr_gen i_rgen (.ACLK, .ARESETn, .bus(rgen));

    sram_array i_array (.ACLK, .mem(mem));

    sram_ctrl i_ctrl (
        .ACLK, .ARESETn,
        .aw_valid, .aw_ready, .aw_req,
        .ar_valid, .ar_ready, .ar_req,
        .wvalid(WVALID), .wready(WREADY), .wdata(WDATA), .wstrb(WSTRB), .wlast(WLAST),
        .bvalid(BVALID), .bready(BREADY), .bid(BID),
        .r_valid, .r_beat, .r_count,
        .mem(mem), .wgen(wgen), .rgen(rgen)
    );

    assign RID   = r_out.id;
    assign RDATA = r_out.data;
    assign RLAST = r_out.last;
    assign RRESP = RESP_OKAY;   // No error responses.
    assign BRESP = RESP_OKAY;

endmodule

// ==== logic/axi_types_pkg.sv ====
//--------------------------------------------------------------------------
// Channel payload types and response codes.
// Only OKAY is ever returned; no error responses exist.
//--------------------------------------------------------------------------
package axi_types_pkg;

    import axi_cfg_pkg::*;

    typedef logic [ID_W-1:0]   id_t;
    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [LEN_W-1:0]  len_t;
    typedef logic [DATA_W-1:0] data_t;

    // One burst request, shared by AW and AR.
    typedef struct packed {
        id_t   id;
        addr_t addr;    // Byte address of the first beat.
        len_t  len;     // Beats minus one.
    } addr_req_t;

    typedef struct packed {
        id_t   id;
        data_t data;
        logic  last;
    } rbeat_t;

    localparam logic [1:0] RESP_OKAY = 2'b00;

endpackage

// ==== logic/burst_addr_gen.sv ====
//--------------------------------------------------------------------------
// Beat counter and word address generator for one INCR burst.
// The word index wraps at the memory size, giving address aliasing.
// Stepping past the final beat leaves the count at zero.
//--------------------------------------------------------------------------
`timescale 1ns/10ps

module burst_addr_gen (
    input logic  ACLK,
    input logic  ARESETn,
    burst_if.gen bus
);

    import axi_cfg_pkg::*;

    logic [LEN_W-1:0] remain;   // Beats left after the current one.

    always_ff @(posedge ACLK) begin
        if (!ARESETn) begin
            remain <= '0;
        end else if (bus.load) begin
            remain <= bus.len;
        end else if (bus.step && (remain != '0)) begin
            remain <= remain - LEN_W'(1);
        end
    end

    always_ff @(posedge ACLK) begin
        if (bus.load) begin
            bus.beat_addr <= bus.base_addr[WORD_SHIFT +: MEM_ADDR_BITS];
        end else if (bus.step) begin
            bus.beat_addr <= bus.beat_addr + MEM_ADDR_BITS'(1); // One word per beat.
        end
    end

    assign bus.last = (remain == '0);

endmodule

// ==== logic/channel_slice.sv ====
//--------------------------------------------------------------------------
// Two-entry valid/ready buffer for any payload type.
// Output valid follows an input transfer by one cycle. in_ready is low
// only when both entries are occupied, so a push into a full buffer is
// never accepted even if a pop happens on the same edge.
//--------------------------------------------------------------------------
`timescale 1ns/10ps

module channel_slice #(
    parameter type payload_t = logic
) (
    input  logic       ACLK,
    input  logic       ARESETn,
    input  logic       in_valid,
    output logic       in_ready,
    input  payload_t   in_data,
    output logic       out_valid,
    input  logic       out_ready,
    output payload_t   out_data,
    output logic [1:0] count
);

    payload_t entry [2];
    logic     wr_ptr;
    logic     rd_ptr;
    logic     push;
    logic     pop;

    assign in_ready  = (count != 2'd2);
    assign out_valid = (count != 2'd0);
    assign out_data  = entry[rd_ptr];     // Head of the queue.
    assign push      = in_valid && in_ready;
    assign pop       = out_valid && out_ready;

    always_ff @(posedge ACLK) begin
        if (!ARESETn) begin
            wr_ptr <= 1'b0;
            rd_ptr <= 1'b0;
            count  <= 2'd0;
        end else begin
            if (push) begin
                wr_ptr <= ~wr_ptr;
            end
            if (pop) begin
                rd_ptr <= ~rd_ptr;
            end
            case ({push, pop})
                2'b10:   count <= count + 2'd1;
                2'b01:   count <= count - 2'd1;
                default: count <= count;      // Idle or pass-through.
            endcase
        end
    end

    always_ff @(posedge ACLK) begin
        if (push) begin
            entry[wr_ptr] <= in_data;
        end
    end

endmodule

// ==== logic/sram_array.sv ====
//--------------------------------------------------------------------------
// Word memory with byte-enabled writes and a registered read port.
// Contents are undefined after power-up; there is no clear.
// A read and a write to the same word on one edge return the old word.
//--------------------------------------------------------------------------
`timescale 1ns/10ps

module sram_array (
    input logic     ACLK,
    mem_port_if.mem mem
);

    import axi_cfg_pkg::*;

    logic [DATA_W-1:0] ram [2**MEM_ADDR_BITS];

    always_ff @(posedge ACLK) begin
        if (mem.wr_en) begin
            for (int i = 0; i < STRB_W; i++) begin
                if (mem.wr_strb[i]) begin
                    ram[mem.wr_addr][8*i +: 8] <= mem.wr_data[8*i +: 8];
                end
            end
        end
    end

    always_ff @(posedge ACLK) begin
        if (mem.rd_en) begin
            mem.rd_data <= ram[mem.rd_addr];    // Held until the next read.
        end
    end

endmodule

// ==== logic/sram_ctrl.sv ====
//--------------------------------------------------------------------------
// Write and read control for the AXI4 SRAM.
// One burst per direction at a time. Reads are issued only while the
// R buffer plus the read in flight hold fewer than two beats, so a
// returned word always finds room. No ordering between reads and writes.
//--------------------------------------------------------------------------
`timescale 1ns/10ps

module sram_ctrl (
    input  logic                            ACLK,
    input  logic                            ARESETn,
    input  logic                            aw_valid,
    output logic                            aw_ready,
    input  axi_types_pkg::addr_req_t        aw_req,
    input  logic                            ar_valid,
    output logic                            ar_ready,
    input  axi_types_pkg::addr_req_t        ar_req,
    input  logic                            wvalid,
    output logic                            wready,
    input  logic [axi_cfg_pkg::DATA_W-1:0]  wdata,
    input  logic [axi_cfg_pkg::STRB_W-1:0]  wstrb,
    input  logic                            wlast,
    output logic                            bvalid,
    input  logic                            bready,
    output logic [axi_cfg_pkg::ID_W-1:0]    bid,
    output logic                            r_valid,
    output axi_types_pkg::rbeat_t           r_beat,
    input  logic [1:0]                      r_count,
    mem_port_if.ctrl                        mem,
    burst_if.ctrl                           wgen,
    burst_if.ctrl                           rgen
);

    import axi_types_pkg::*;

    typedef enum logic [1:0] {W_IDLE, W_DATA, W_RESP} wstate_t;
    typedef enum logic       {R_IDLE, R_STREAM}       rstate_t;

    wstate_t    wstate;
    rstate_t    rstate;
    id_t        rid_q;
    logic       rd_pending;     // Word arrives from the array this cycle.
    logic       rd_last_q;
    logic       w_beat;
    logic       issue;
    logic [1:0] credit_used;

    // Write side.
    assign aw_ready = (wstate == W_IDLE);
    assign wready   = (wstate == W_DATA);
    assign bvalid   = (wstate == W_RESP);
    assign w_beat   = wready && wvalid;

    assign wgen.load      = aw_valid && aw_ready;
    assign wgen.base_addr = aw_req.addr;
    assign wgen.len       = aw_req.len;
    assign wgen.step      = w_beat;

    assign mem.wr_en   = w_beat;
    assign mem.wr_addr = wgen.beat_addr;
    assign mem.wr_data = wdata;
    assign mem.wr_strb = wstrb;

    always_ff @(posedge ACLK) begin
        if (!ARESETn) begin
            wstate <= W_IDLE;
        end else begin
            case (wstate)
                W_IDLE: if (wgen.load) wstate <= W_DATA;
                W_DATA: if (w_beat && (wlast || wgen.last)) wstate <= W_RESP; // End of data.
                W_RESP: if (bready) wstate <= W_IDLE;
                default: wstate <= W_IDLE;
            endcase
        end
    end

    always_ff @(posedge ACLK) begin
        if (wgen.load) begin
            bid <= aw_req.id;
        end
    end

    // Read side.
    assign ar_ready       = (rstate == R_IDLE);
    assign rgen.load      = ar_valid && ar_ready;
    assign rgen.base_addr = ar_req.addr;
    assign rgen.len       = ar_req.len;

    assign credit_used = r_count + {1'b0, rd_pending};
    assign issue       = (rstate == R_STREAM) && (credit_used < 2'd2);
    assign rgen.step   = issue;

    assign mem.rd_en   = issue;
    assign mem.rd_addr = rgen.beat_addr;

    // Returned word goes straight into the R buffer.
    assign r_valid = rd_pending;
    assign r_beat  = '{id: rid_q, data: mem.rd_data, last: rd_last_q};

    always_ff @(posedge ACLK) begin
        if (!ARESETn) begin
            rstate     <= R_IDLE;
            rd_pending <= 1'b0;
        end else begin
            rd_pending <= issue;
            case (rstate)
                R_IDLE:   if (rgen.load) rstate <= R_STREAM;
                R_STREAM: if (issue && rgen.last) rstate <= R_IDLE; // Last beat issued.
                default:  rstate <= R_IDLE;
            endcase
        end
    end

    always_ff @(posedge ACLK) begin
        if (rgen.load) begin
            rid_q <= ar_req.id;
        end
        if (issue) begin
            rd_last_q <= rgen.last;
        end
    end

endmodule

// ==== logic/sram_ifs.sv ====
//--------------------------------------------------------------------------
// Internal links of the SRAM subsystem.
// mem_port_if: one write and one read port; rd_data is valid the cycle
// after rd_en and holds until the next read.
// burst_if: load and step are single-cycle strobes from the controller.
//--------------------------------------------------------------------------
`timescale 1ns/10ps

interface mem_port_if;

    import axi_cfg_pkg::*;
    import axi_types_pkg::*;

    logic                     wr_en;
    logic [MEM_ADDR_BITS-1:0] wr_addr;
    data_t                    wr_data;
    logic [STRB_W-1:0]        wr_strb;
    logic                     rd_en;
    logic [MEM_ADDR_BITS-1:0] rd_addr;
    data_t                    rd_data;

    modport ctrl (output wr_en, wr_addr, wr_data, wr_strb, rd_en, rd_addr, input rd_data);
    modport mem  (input wr_en, wr_addr, wr_data, wr_strb, rd_en, rd_addr, output rd_data);

endinterface

interface burst_if;

    import axi_cfg_pkg::*;
    import axi_types_pkg::*;

    logic                     load;
    addr_t                    base_addr;
    len_t                     len;
    logic                     step;
    logic [MEM_ADDR_BITS-1:0] beat_addr;   // Word index of the current beat.
    logic                     last;

    modport ctrl (output load, base_addr, len, step, input beat_addr, last);
    modport gen  (input load, base_addr, len, step, output beat_addr, last);

endinterface

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the AXI SRAM testbench with Verilator.
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert --timing --top-module axi_sram_tb -Mdir obj_dir -f sources.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vaxi_sram_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q '^\*\*\* PASSED \*\*\*$' "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1

// ==== sources.f ====
logic/axi_cfg_pkg.sv
logic/axi_types_pkg.sv
logic/sram_ifs.sv
logic/channel_slice.sv
logic/burst_addr_gen.sv
logic/sram_array.sv
logic/sram_ctrl.sv
logic/axi_sram_top.sv
bench/axi_sram_asserts.sv
bench/axi_sram_tb.sv
